// ==== files.f ====
source/norm_pkg.sv
source/norm_datapath.sv
source/norm_sequencer.sv
source/norm_output_stage.sv
source/norm_top.sv
sim/norm_assertions.sv
sim/norm_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds the normalization testbench with verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module norm_tb -f files.f -o norm_sim &&
./obj_dir/norm_sim | tee /dev/stderr | grep -qF "RESULT: PASS" &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }

// ==== sim/norm_tb.sv ====
`timescale 1ns/10ps

// testbench for the normalization block
// random bursts in normalizing and bypass mode are checked against a
// model that follows the lane rule and the latency of each mode
module norm_tb;

    localparam int dw = norm_pkg::dwidth;
    localparam int mw = norm_pkg::mask_width;
    localparam int mm = norm_pkg::mat_mul_size;
    localparam int num_bursts = 200;
    localparam int reset_cycles = 8;
    // a burst takes at most 4 columns, 6 gap cycles and 4 idle cycles
    localparam int timeout_cycles = num_bursts * 16 + 100;

    logic clk;
    logic arst_n;
    logic enable_norm;
    logic [dw-1:0] mean;
    logic [dw-1:0] inv_var;
    logic in_valid;
    norm_pkg::column_t in_data;
    logic [mw-1:0] validity_mask;
    logic out_valid;
    norm_pkg::column_t out_data;
    logic done;

    // expected columns in output order, with the edge they are due on
    norm_pkg::column_t q_data[$];
    int q_due[$];
    bit q_last[$];

    int edge_cnt = 0;
    int burst_cnt = 0;
    int cycle_count = 0;
    logic en_last = 1'b1;

    int data_errors = 0;
    int bit_errors = 0;
    int other_errors = 0;
    int columns_checked = 0;

    norm_top dut_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .enable_norm   (enable_norm),
        .mean          (mean),
        .inv_var       (inv_var),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .validity_mask (validity_mask),
        .out_valid     (out_valid),
        .out_data      (out_data),
        .done          (done)
    );

    always #20 clk = ~clk;

    // one lane after subtract and scale, wrapping in 8 bits
    function automatic logic [dw-1:0] expect_lane(input logic [dw-1:0] x,
                                                  input logic [dw-1:0] m,
                                                  input logic [dw-1:0] iv,
                                                  input logic on);
        logic [dw-1:0] diff;
        logic [2*dw-1:0] prod;
        diff = x - m;
        prod = {{dw{1'b0}}, diff} * {{dw{1'b0}}, iv};
        return on ? prod[dw-1:0] : x;
    endfunction

    // in bypass mode the whole column is a plain copy
    function automatic norm_pkg::column_t expect_column(input norm_pkg::column_t x,
                                                        input logic [mw-1:0] mask,
                                                        input logic [dw-1:0] m,
                                                        input logic [dw-1:0] iv,
                                                        input logic en);
        norm_pkg::column_t result;
        for (int i = 0; i < mm; i++) begin
            result.lane[i] = expect_lane(x.lane[i], m, iv, en && mask[i]);
        end
        return result;
    endfunction

    task automatic check_column(input string name, input norm_pkg::column_t exp_col,
                                input norm_pkg::column_t act_col);
        for (int i = 0; i < mm; i++) begin
            if (act_col.lane[i] !== exp_col.lane[i]) begin
                $display("CHECK FAILED at %0t: %s lane %0d expected %h actual %h",
                         $time, name, i, exp_col.lane[i], act_col.lane[i]);
                data_errors++;
            end
        end
    endtask

    task automatic check_bit(input string name, input logic exp_bit, input logic act_bit);
        if (act_bit !== exp_bit) begin
            $display("CHECK FAILED at %0t: %s expected %b actual %b",
                     $time, name, exp_bit, act_bit);
            bit_errors++;
        end
    endtask

    // prints the counts and ends the run either way
    task automatic close_run();
        $display("errors: data %0d, valid and done %0d, other %0d, columns checked %0d",
                 data_errors, bit_errors, other_errors, columns_checked);
        if (data_errors + bit_errors + other_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // the model samples the inputs as the DUT does, on the rising edge
    always @(posedge clk) begin
        if (arst_n) begin
            edge_cnt = edge_cnt + 1;
            en_last = enable_norm;
            if (!enable_norm) begin
                burst_cnt = 0;
            end
            if (in_valid) begin
                q_data.push_back(expect_column(in_data, validity_mask, mean, inv_var,
                                               enable_norm));
                if (enable_norm) begin
                    // stage one on this edge, stage two and output on the next two
                    q_due.push_back(edge_cnt + 2);
                    q_last.push_back(burst_cnt == mm - 1);
                    burst_cnt = (burst_cnt + 1) % mm;
                end else begin
                    q_due.push_back(edge_cnt);
                    q_last.push_back(1'b0);
                end
            end
        end
    end

    // outputs are compared at the falling edge, where they are stable
    always @(negedge clk) begin
        logic exp_valid;
        logic exp_done;
        if (arst_n) begin
            exp_valid = 1'b0;
            exp_done = !en_last;
            if (q_due.size() > 0) begin
                if (q_due[0] == edge_cnt) begin
                    exp_valid = 1'b1;
                    // done only goes with the column that closes a burst
                    if (en_last) begin
                        exp_done = q_last[0];
                    end
                end
            end
            check_bit("out_valid", exp_valid, out_valid);
            check_bit("done", exp_done, done);
            if (exp_valid) begin
                check_column("out_data", q_data[0], out_data);
                columns_checked++;
                void'(q_data.pop_front());
                void'(q_due.pop_front());
                void'(q_last.pop_front());
            end
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("timeout, the run did not finish within %0d cycles", timeout_cycles);
            other_errors++;
            close_run();
        end
    end

    initial begin
        norm_pkg::column_t col;
        logic burst_en;
        logic [dw-1:0] burst_mean;
        logic [dw-1:0] burst_inv_var;
        int unsigned gap_pct;
        int gaps;
        void'($urandom(89305));
        clk = 1'b0;
        arst_n = 1'b0;
        enable_norm = 1'b1;
        mean = '0;
        inv_var = '0;
        in_valid = 1'b0;
        in_data = '0;
        validity_mask = '0;

        // everything must read zero while reset is held
        repeat (reset_cycles - 1) @(posedge clk);
        @(negedge clk);
        check_bit("out_valid", 1'b0, out_valid);
        check_bit("done", 1'b0, done);
        check_column("out_data", '0, out_data);
        @(posedge clk);
        arst_n <= 1'b1;

        for (int b = 0; b < num_bursts; b++) begin
            burst_en = 1'($urandom);
            burst_mean = dw'($urandom);
            burst_inv_var = dw'($urandom);
            gap_pct = $urandom_range(60, 0);
            for (int c = 0; c < mm; c++) begin
                // at most two idle cycles between the columns of a burst
                gaps = 0;
                while (c > 0 && gaps < 2 && $urandom_range(99, 0) < gap_pct) begin
                    @(posedge clk);
                    in_valid <= 1'b0;
                    gaps++;
                end
                for (int i = 0; i < mm; i++) begin
                    col.lane[i] = dw'($urandom);
                end
                @(posedge clk);
                enable_norm <= burst_en;
                mean <= burst_mean;
                inv_var <= burst_inv_var;
                in_valid <= 1'b1;
                in_data <= col;
                validity_mask <= mw'($urandom);
            end
            // the pipeline drains before the enable may change
            repeat (4) begin
                @(posedge clk);
                in_valid <= 1'b0;
            end
        end

        repeat (6) @(posedge clk);
        @(negedge clk);
        if (q_data.size() != 0) begin
            $display("%0d expected columns never appeared at the output", q_data.size());
            other_errors++;
        end
        close_run();
    end

endmodule

// ==== sim/norm_assertions.sv ====
`timescale 1ns/10ps

// protocol checks on the outputs of the normalization block
module norm_assertions (
    input logic clk,
    input logic arst_n,
    input logic enable_norm,
    input logic in_valid,
    input logic out_valid,
    input logic done
);

    // while normalizing, done marks the last column and never stands alone
    done_with_valid: assert property (
        @(posedge clk) disable iff (!arst_n)
        ($past(enable_norm) && done) |-> out_valid
    ) else $error("done without out_valid in normalizing mode");

    // a normalized column leaves three edges after it was taken in
    valid_has_source: assert property (
        @(posedge clk) disable iff (!arst_n)
        ($past(enable_norm) && out_valid) |-> $past(in_valid, 3)
    ) else $error("out_valid without an in_valid three cycles earlier");

    // the registers are cleared by the edge that sees reset low
    quiet_in_reset: assert property (
        @(posedge clk)
        !arst_n |=> (!out_valid && !done)
    ) else $error("out_valid or done high during reset");

endmodule

bind norm_top norm_assertions assertions_i (
    .clk         (clk),
    .arst_n      (arst_n),
    .enable_norm (enable_norm),
    .in_valid    (in_valid),
    .out_valid   (out_valid),
    .done        (done)
);

// ==== source/norm_top.sv ====
`timescale 1ns/10ps

// normalization block that follows the systolic matrix-multiply array
// each lane of a column has the mean subtracted and is then scaled by
// the inverse variance, both in 8-bit wrap-around arithmetic
// there is no ready signal, every presented column is accepted
module norm_top (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              enable_norm,
    input  logic [norm_pkg::dwidth-1:0]       mean,
    input  logic [norm_pkg::dwidth-1:0]       inv_var,
    input  logic                              in_valid,
    input  norm_pkg::column_t                 in_data,
    input  logic [norm_pkg::mask_width-1:0]   validity_mask,
    output logic                              out_valid,
    output norm_pkg::column_t                 out_data,
    output logic                              done
);

    // result of the second datapath stage
    norm_pkg::column_t norm_data;

    // controls from the sequencer to the output register
    logic sel_norm;
    logic next_valid;
    logic next_done;

    // two pipelined lane stages, subtract then multiply
    norm_datapath datapath_i (
        .clk           (clk),
        .arst_n        (arst_n),
        .in_valid      (in_valid),
        .in_data       (in_data),
        .validity_mask (validity_mask),
        .mean          (mean),
        .inv_var       (inv_var),
        .norm_data     (norm_data)
    );

    // counts columns and tracks them through the datapath
    norm_sequencer sequencer_i (
        .clk         (clk),
        .arst_n      (arst_n),
        .enable_norm (enable_norm),
        .in_valid    (in_valid),
        .sel_norm    (sel_norm),
        .next_valid  (next_valid),
        .next_done   (next_done)
    );

    // the raw column goes straight here for the bypass path
    norm_output_stage output_stage_i (
        .clk        (clk),
        .arst_n     (arst_n),
        .sel_norm   (sel_norm),
        .next_valid (next_valid),
        .next_done  (next_done),
        .norm_data  (norm_data),
        .in_data    (in_data),
        .out_valid  (out_valid),
        .done       (done),
        .out_data   (out_data)
    );

endmodule

// ==== source/norm_output_stage.sv ====
`timescale 1ns/10ps

// output register of the normalization block
// it takes either the normalized column or the raw input column
// and registers data, valid and done together
module norm_output_stage (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              sel_norm,
    input  logic              next_valid,
    input  logic              next_done,
    input  norm_pkg::column_t norm_data,
    input  norm_pkg::column_t in_data,
    output logic              out_valid,
    output logic              done,
    output norm_pkg::column_t out_data
);

    // the column that would be loaded on this edge
    logic [norm_pkg::mat_mul_size*norm_pkg::dwidth-1:0] next_data;

    // the raw column is used in bypass mode and arrives one edge later
    assign next_data = sel_norm ? norm_data.flat : in_data.flat;

    // out_data only changes when a column is presented,
    // between columns it keeps the last one
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_data.flat <= '0;
        end else if (next_valid) begin
            out_data.flat <= next_data;
        end
    end

    // valid and done are plain strobes, loaded on every edge
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_valid <= 1'b0;
            done      <= 1'b0;
        end else begin
            out_valid <= next_valid;
            done      <= next_done;
        end
    end

endmodule

// ==== source/norm_sequencer.sv ====
`timescale 1ns/10ps

// column sequencer for the normalization block
// it runs beside the lane datapath and tells the output stage when a
// column is ready, which source to take and when a burst has ended
module norm_sequencer (
    input  logic clk,
    input  logic arst_n,
    input  logic enable_norm,
    input  logic in_valid,
    output logic sel_norm,
    output logic next_valid,
    output logic next_done
);

    // registered copy of the enable
    logic mode_q;

    // number of enabled columns seen so far in the current burst
    logic [norm_pkg::count_width-1:0] col_count;

    // a column that enters the normalizing pipeline
    logic col_accept;

    // this column closes the burst
    logic col_last;

    // bit 0 follows stage one of the datapath, bit 1 follows stage two
    logic [1:0] valid_pipe;

    // end of burst flag that travels with each valid bit
    logic [1:0] last_pipe;

    assign col_accept = in_valid & enable_norm;
    assign col_last   = col_accept && (col_count == norm_pkg::last_count);

    // the counter wraps on its own after the last column of a burst
    // gaps between columns simply leave it where it is
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            col_count <= '0;
        end else if (!enable_norm) begin
            col_count <= '0;
        end else if (in_valid) begin
            col_count <= col_count + 1'b1;
        end
    end

    // valid and last shift in step with the two datapath stages
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_pipe <= '0;
            last_pipe  <= '0;
        end else begin
            valid_pipe <= {valid_pipe[0], col_accept};
            last_pipe  <= {last_pipe[0], col_last};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mode_q <= 1'b0;
        end else begin
            mode_q <= enable_norm;
        end
    end

    // normalized data needs three edges to arrive, so the registered
    // enable covers it, while a falling enable must switch the output
    // to the raw column at once for the first bypassed column
    assign sel_norm = mode_q & enable_norm;

    // the enable only moves while the pipeline is empty, so the live
    // level picks the right valid and done for whatever is arriving
    assign next_valid = enable_norm ? valid_pipe[1] : in_valid;

    // with the block disabled done is held high
    assign next_done = enable_norm ? last_pipe[1] : 1'b1;

endmodule

// ==== source/norm_datapath.sv ====
`timescale 1ns/10ps

// lane datapath of the normalization block
// stage one subtracts the mean, stage two scales by the inverse variance
// lanes whose mask bit is clear are carried through both stages unchanged
module norm_datapath (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              in_valid,
    input  norm_pkg::column_t                 in_data,
    input  logic [norm_pkg::mask_width-1:0]   validity_mask,
    input  logic [norm_pkg::dwidth-1:0]       mean,
    input  logic [norm_pkg::dwidth-1:0]       inv_var,
    output norm_pkg::column_t                 norm_data
);

    // stage one results, one lane per mask bit
    norm_pkg::column_t s1_data;

    // mask of the column held in stage one
    logic [norm_pkg::mask_width-1:0] s1_mask;

    // stage one holds a fresh column that stage two must pick up
    logic s1_valid;

    // stage two results, which feed the output stage directly
    norm_pkg::column_t s2_data;

    // the strobe for stage two is the input strobe one cycle late
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= in_valid;
        end
    end

    // stage one loads only on a strobe and holds its column otherwise
    always_ff @(posedge clk) begin
        if (in_valid) begin
            s1_mask <= validity_mask;
            for (int i = 0; i < norm_pkg::mat_mul_size; i++) begin
                // the subtraction wraps in 8 bits, so no sign handling
                if (validity_mask[i]) begin
                    s1_data.lane[i] <= in_data.lane[i] - mean;
                end else begin
                    s1_data.lane[i] <= in_data.lane[i];
                end
            end
        end
    end

    // stage two uses the mask that was captured with the column,
    // not the mask that is on the input port now
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            for (int i = 0; i < norm_pkg::mat_mul_size; i++) begin
                // only the low 8 bits of the product are kept
                if (s1_mask[i]) begin
                    s2_data.lane[i] <= s1_data.lane[i] * inv_var;
                end else begin
                    s2_data.lane[i] <= s1_data.lane[i];
                end
            end
        end
    end

    // mean and inv_var are not staged, they stay stable over a burst
    assign norm_data = s2_data;

endmodule

// ==== source/norm_pkg.sv ====
// shared widths and the column type for the normalization block
// that sits behind the systolic matrix-multiply array
package norm_pkg;

    // width of one lane value
    localparam int dwidth = 8;

    // lanes per column, which is also the number of columns in one burst
    localparam int mat_mul_size = 4;

    // one mask bit per lane, set means the lane is normalized
    localparam int mask_width = mat_mul_size;

    // the column counter only has to reach mat_mul_size minus one
    localparam int count_width = 2;

    // counter value that marks the last column of a burst
    localparam logic [count_width-1:0] last_count = count_width'(mat_mul_size - 1);

    // one column of the array output, read either as a single word
    // or as separate lanes
    // lane 0 sits in the low bits of the flat word
    typedef union packed {
        logic [mat_mul_size*dwidth-1:0] flat;
        logic [mat_mul_size-1:0][dwidth-1:0] lane;
    } column_t;

endpackage
